// File: src.f
src/spi_pkg.sv
src/spi_clock_gen.sv
src/spi_master.sv
src/spi_echo_target.sv
src/spi_subsystem_top.sv
testbench/spi_properties.sv
testbench/spi_tb.sv

// File: run_sim.sh
#!/bin/sh
# Build the testbench with Verilator, run it and judge the log.
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f src.f --top-module spi_tb -o spi_sim \
    > build.log 2>&1 || { cat build.log; echo "build failed"; exit 1; }

./obj_dir/spi_sim > sim.log 2>&1
cat sim.log

grep -q "FAIL: see errors above" sim.log && { echo "simulation failed"; exit 1; }
grep -q "PASS: all tests" sim.log || { echo "simulation ended without a result"; exit 1; }
exit 0

// File: testbench/spi_tb.sv
`timescale 1ns/1ps
`default_nettype none

module spi_tb;
    import spi_pkg::*;

    // ==================================================
    // Test setup
    // ==================================================

    localparam int CLK_PERIOD      = 8;
    localparam int RESET_CYCLES    = 8;
    localparam int NUM_TESTS       = 16;
    localparam int CYCLES_PER_TEST = 2 + 16 * SCLK_DIV + 10;
    localparam int WATCHDOG_CYCLES = NUM_TESTS * CYCLES_PER_TEST + RESET_CYCLES;
    localparam int DONE_LIMIT      = 2 + 2 * SCLK_DIV * WORD_WIDTH + 4;

    localparam logic [16:0] LFSR_SEED = 17'd78590;

    localparam size_t TEST_SIZES [NUM_TESTS] = '{
        4'd8, 4'd8, 4'd1, 4'd2, 4'd3, 4'd4, 4'd5, 4'd6,
        4'd7, 4'd0, 4'd8, 4'd0, 4'd5, 4'd3, 4'd8, 4'd1
    };

    // Tests 1, 4, 10 and 12 fire a second start mid-frame.
    localparam logic [NUM_TESTS-1:0] POKE_MASK = 16'b0001_0100_0001_0010;

    typedef struct packed {
        size_t size;
        word_t data;
        logic  poke;        // Extra start while busy.
        word_t exp_rsp;
        word_t exp_reply;   // Target reply after the frame.
    } test_vec_t;

    logic        spi_clk = 1'b0;
    logic        rstn;
    logic        start;
    xfer_req_t   req;
    word_t       rsp_data;
    logic        busy;
    logic        done;
    spi_bus_t    bus;
    logic        miso;

    test_vec_t   test_table [NUM_TESTS];
    logic [16:0] lfsr_state  = LFSR_SEED;
    int          error_count = 0;
    int          pass_count  = 0;
    int          test_count  = 0;
    int          rise_count  = 0;
    int          done_count  = 0;
    int          total_done  = 0;
    logic        cs_low_seen = 1'b0;
    logic        sclk_prev   = 1'b0;

    spi_subsystem_top DUT (
        .spi_clk  (spi_clk),
        .rstn     (rstn),
        .start    (start),
        .req      (req),
        .rsp_data (rsp_data),
        .busy     (busy),
        .done     (done),
        .bus      (bus),
        .miso     (miso)
    );

    always #(CLK_PERIOD / 2) spi_clk = ~spi_clk;

    // Pin activity is sampled away from the active edge.
    always @(negedge spi_clk)
    begin
        if (rstn)
        begin
            if (bus.sclk && !sclk_prev && !bus.cs_n)
                rise_count++;
            if (!bus.cs_n)
                cs_low_seen = 1'b1;
            if (done)
            begin
                done_count++;
                total_done++;
            end
        end
        sclk_prev = bus.sclk;
    end

    // ==================================================
    // Stimulus and reference model
    // ==================================================

    // Taps 17 and 14.
    function automatic logic [16:0] lfsr_next(input logic [16:0] s);
        return {s[15:0], s[16] ^ s[13]};
    endfunction

    task automatic draw_word(output word_t w);
        int b;
        w = '0;
        for (b = 0; b < WORD_WIDTH; b++)
        begin
            lfsr_state = lfsr_next(lfsr_state);
            w = {w[WORD_WIDTH-2:0], lfsr_state[0]};
        end
    endtask

    task automatic build_table();
        word_t reply;
        word_t last_rsp;
        word_t data;
        int    drop;
        int    i;
        reply    = TARGET_RESET_REPLY;
        last_rsp = '0;
        for (i = 0; i < NUM_TESTS; i++)
        begin
            draw_word(data);
            test_table[i].size = TEST_SIZES[i];
            test_table[i].data = data;
            test_table[i].poke = POKE_MASK[i];
            if (TEST_SIZES[i] != '0)
            begin
                drop     = WORD_WIDTH - int'(TEST_SIZES[i]);
                last_rsp = reply >> drop;    // Top N bits of the old reply.
                reply    = data >> drop;
            end
            test_table[i].exp_rsp   = last_rsp;
            test_table[i].exp_reply = reply;
        end
    endtask

    // ==================================================
    // Checks
    // ==================================================

    task automatic check_value(input string name, input int got, input int exp);
        assert (got == exp)
        else
        begin
            $display("mismatch %s: got 0x%0h, expected 0x%0h", name, got, exp);
            error_count++;
        end
    endtask

    task automatic report_test(input string what, input int errors_before);
        test_count++;
        if (error_count == errors_before)
            pass_count++;
        $display("test %2d: %s  %s", test_count - 1, what,
                 (error_count == errors_before) ? "ok" : "failed");
    endtask

    task automatic check_reset_state();
        int errors_before;
        errors_before = error_count;
        check_value("cs_n", int'(bus.cs_n), 1);
        check_value("sclk", int'(bus.sclk), 0);
        check_value("mosi", int'(bus.mosi), 0);
        check_value("miso", int'(miso), 0);
        check_value("busy", int'(busy), 0);
        check_value("done", int'(done), 0);
        check_value("rsp_data", int'(rsp_data), 0);
        report_test("reset state", errors_before);
    endtask

    task automatic run_test(input int idx);
        test_vec_t tv;
        int        cycles;
        int        errors_before;
        tv            = test_table[idx];
        errors_before = error_count;

        @(negedge spi_clk);
        rise_count  = 0;
        done_count  = 0;
        cs_low_seen = 1'b0;
        start       = 1'b1;
        req.data    = tv.data;
        req.size    = tv.size;
        cycles      = 0;

        do
        begin
            @(negedge spi_clk);
            cycles++;
            start = 1'b0;
            check_value("busy", int'(busy), 1);
            if (tv.poke && cycles == 2 && !done)
            begin
                start    = 1'b1;    // Master is in the frame by now.
                req.data = ~tv.data;
                req.size = size_t'(WORD_WIDTH);
            end
        end
        while (!done && cycles < DONE_LIMIT);
        start = 1'b0;

        assert (done)
        else
        begin
            $display("test %0d got no done pulse within %0d cycles of start",
                     idx + 1, DONE_LIMIT);
            error_count++;
        end

        if (done)
        begin
            check_value("rsp_data", int'(rsp_data), int'(tv.exp_rsp));
            @(negedge spi_clk);
            @(negedge spi_clk);     // Target reply is latched by now.
            check_value("done pulses", done_count, 1);
            check_value("sclk rises", rise_count, int'(tv.size));
            check_value("cs_n low seen", int'(cs_low_seen), int'(tv.size != '0));
            check_value("echo reply", int'(DUT.u_target.reply), int'(tv.exp_reply));
            check_value("rsp_data held", int'(rsp_data), int'(tv.exp_rsp));
            check_value("busy", int'(busy), 0);
        end

        report_test($sformatf("size %0d data 0x%02h poke %0b rsp 0x%02h",
                              tv.size, tv.data, tv.poke, rsp_data), errors_before);
    endtask

    // ==================================================
    // Main sequence and watchdog
    // ==================================================

    initial
    begin
        int idx;
        rstn  = 1'b0;
        start = 1'b0;
        req   = '0;
        build_table();
        repeat (RESET_CYCLES) @(negedge spi_clk);
        rstn = 1'b1;
        check_reset_state();

        for (idx = 0; idx < NUM_TESTS; idx++)
            run_test(idx);

        check_value("done pulses in total", total_done, NUM_TESTS);
        assert (DUT.u_master.u_props.fail_count == 0)
        else
        begin
            $display("pin assertions failed %0d times",
                     DUT.u_master.u_props.fail_count);
            error_count++;
        end

        $display("tests %0d, passed %0d, failed %0d, errors %0d",
                 test_count, pass_count, test_count - pass_count, error_count);
        if (error_count == 0)
            $display("PASS: all tests");
        else
            $display("FAIL: see errors above");
        $finish;
    end

    initial
    begin
        #(WATCHDOG_CYCLES * CLK_PERIOD);
        $display("timeout: tests still running after %0d cycles", WATCHDOG_CYCLES);
        $display("FAIL: see errors above");
        $finish;
    end

endmodule

`default_nettype wire

// File: testbench/spi_properties.sv
`timescale 1ns/1ps
`default_nettype none

module spi_properties (
    input logic              spi_clk,
    input logic              rstn,
    input spi_pkg::spi_bus_t bus,
    input logic              done
);

    int fail_count = 0;     // Read by the testbench.

    // ==================================================
    // Serial pin rules
    // ==================================================

    sclk_low_when_idle: assert property (@(posedge spi_clk) disable iff (!rstn)
        bus.cs_n |-> !bus.sclk)
    else
    begin
        $error("sclk is high while cs_n is high");
        fail_count++;
    end

    // Target samples on the high phase.
    mosi_stable_in_high: assert property (@(posedge spi_clk) disable iff (!rstn)
        bus.sclk |-> $stable(bus.mosi))
    else
    begin
        $error("mosi changed while sclk is high");
        fail_count++;
    end

    done_single_cycle: assert property (@(posedge spi_clk) disable iff (!rstn)
        done |=> !done)
    else
    begin
        $error("done stayed high for two cycles");
        fail_count++;
    end

endmodule

bind spi_master spi_properties u_props (
    .spi_clk (spi_clk),
    .rstn    (rstn),
    .bus     (bus),
    .done    (done)
);

`default_nettype wire

// File: src/spi_subsystem_top.sv
`timescale 1ns/1ps
`default_nettype none

module spi_subsystem_top (
    input  logic               spi_clk,
    input  logic               rstn,
    input  logic               start,
    input  spi_pkg::xfer_req_t req,
    output spi_pkg::word_t     rsp_data,
    output logic               busy,
    output logic               done,
    output spi_pkg::spi_bus_t  bus,
    output logic               miso
);

    logic run;
    logic sclk_rise;
    logic sclk_fall;

    // ==================================================
    // Master side
    // ==================================================

    spi_clock_gen u_clock_gen (
        .spi_clk   (spi_clk),
        .rstn      (rstn),
        .run       (run),
        .sclk_rise (sclk_rise),
        .sclk_fall (sclk_fall)
    );

    spi_master u_master (
        .spi_clk   (spi_clk),
        .rstn      (rstn),
        .start     (start),
        .req       (req),
        .sclk_rise (sclk_rise),
        .sclk_fall (sclk_fall),
        .miso      (miso),
        .run       (run),
        .bus       (bus),
        .rsp_data  (rsp_data),
        .busy      (busy),
        .done      (done)
    );

    // ==================================================
    // Target side
    // ==================================================

    spi_echo_target u_target (
        .spi_clk (spi_clk),
        .rstn    (rstn),
        .bus     (bus),
        .miso    (miso)     // Also brought out for observation.
    );

endmodule

`default_nettype wire

// File: src/spi_echo_target.sv
`timescale 1ns/1ps
`default_nettype none

module spi_echo_target (
    input  logic              spi_clk,
    input  logic              rstn,
    input  spi_pkg::spi_bus_t bus,
    output logic              miso
);
    import spi_pkg::*;

    logic  sclk_q;
    logic  cs_n_q;
    logic  sclk_up;
    logic  sclk_down;
    logic  frame_start;
    logic  frame_end;
    word_t reply;       // Sent back in the next frame.
    word_t rx_shift;
    word_t tx_shift;

    // ==================================================
    // Pin edge detection
    // ==================================================

    assign sclk_up     = bus.sclk && !sclk_q && !bus.cs_n;
    assign sclk_down   = !bus.sclk && sclk_q && !bus.cs_n;
    assign frame_start = !bus.cs_n && cs_n_q;
    assign frame_end   = bus.cs_n && !cs_n_q;

    // ==================================================
    // Reply register and miso driver
    // ==================================================

    always_ff @(posedge spi_clk)
    begin
        if (!rstn)
        begin
            sclk_q <= 1'b0;
            cs_n_q <= 1'b1;
            reply  <= TARGET_RESET_REPLY;
            miso   <= 1'b0;
        end
        else
        begin
            sclk_q <= bus.sclk;
            cs_n_q <= bus.cs_n;
            if (frame_start)
            begin
                miso <= reply[WORD_WIDTH-1];    // MSB out with cs_n.
            end
            else if (frame_end)
            begin
                miso  <= 1'b0;
                reply <= rx_shift;              // Zero-extended by the clear.
            end
            else if (sclk_down)
            begin
                miso <= tx_shift[WORD_WIDTH-2];
            end
        end
    end

    // ==================================================
    // Shift registers
    // ==================================================

    always_ff @(posedge spi_clk)
    begin
        if (frame_start)
        begin
            rx_shift <= '0;
            tx_shift <= reply;
        end
        else
        begin
            if (sclk_up)
                rx_shift <= {rx_shift[WORD_WIDTH-2:0], bus.mosi};
            if (sclk_down)
                tx_shift <= {tx_shift[WORD_WIDTH-2:0], 1'b0};
        end
    end

endmodule

`default_nettype wire

// File: src/spi_master.sv
`timescale 1ns/1ps
`default_nettype none

module spi_master (
    input  logic               spi_clk,
    input  logic               rstn,
    input  logic               start,
    input  spi_pkg::xfer_req_t req,
    input  logic               sclk_rise,
    input  logic               sclk_fall,
    input  logic               miso,
    output logic               run,
    output spi_pkg::spi_bus_t  bus,
    output spi_pkg::word_t     rsp_data,
    output logic               busy,
    output logic               done
);
    import spi_pkg::*;

    typedef enum logic [1:0] {
        IDLE,
        LOAD,
        TRANSACT,
        UNLOAD
    } state_t;

    state_t    state;
    xfer_req_t req_q;       // Request held from start.
    word_t     tx_shift;
    word_t     rx_shift;
    size_t     bit_cnt;     // Bits still to send.

    // ==================================================
    // Transfer FSM and pin drivers
    // ==================================================

    always_ff @(posedge spi_clk)
    begin
        if (!rstn)
        begin
            state    <= IDLE;
            bit_cnt  <= '0;
            bus.sclk <= 1'b0;
            bus.mosi <= 1'b0;
            bus.cs_n <= 1'b1;
            rsp_data <= '0;
        end
        else
        begin
            case (state)
                IDLE:
                begin
                    if (start)
                        state <= LOAD;
                end
                LOAD:
                begin
                    bit_cnt <= req_q.size;
                    if (req_q.size == '0)
                    begin
                        state <= UNLOAD;    // Nothing to move.
                    end
                    else
                    begin
                        state    <= TRANSACT;
                        bus.cs_n <= 1'b0;
                        bus.mosi <= req_q.data[WORD_WIDTH-1];   // First bit with cs_n.
                    end
                end
                TRANSACT:
                begin
                    if (sclk_rise)
                        bus.sclk <= 1'b1;
                    if (sclk_fall)
                    begin
                        bus.sclk <= 1'b0;
                        bit_cnt  <= bit_cnt - 1'b1;
                        if (bit_cnt == size_t'(1))
                        begin
                            // Last bit is in, so close the frame.
                            state    <= UNLOAD;
                            bus.cs_n <= 1'b1;
                            bus.mosi <= 1'b0;
                            rsp_data <= rx_shift;   // Valid together with done.
                        end
                        else
                        begin
                            bus.mosi <= tx_shift[WORD_WIDTH-2];
                        end
                    end
                end
                UNLOAD:
                begin
                    state <= IDLE;
                end
                default:
                begin
                    state <= IDLE;
                end
            endcase
        end
    end

    // ==================================================
    // Shift registers
    // ==================================================

    always_ff @(posedge spi_clk)
    begin
        case (state)
            IDLE:
            begin
                if (start)
                    req_q <= req;
            end
            LOAD:
            begin
                tx_shift <= req_q.data;
                rx_shift <= '0;     // Result ends up right-justified.
            end
            TRANSACT:
            begin
                if (sclk_rise)
                    rx_shift <= {rx_shift[WORD_WIDTH-2:0], miso};
                if (sclk_fall)
                    tx_shift <= {tx_shift[WORD_WIDTH-2:0], 1'b0};
            end
            default:
            begin
                tx_shift <= tx_shift;
            end
        endcase
    end

    // ==================================================
    // Status
    // ==================================================

    assign run  = (state == TRANSACT);
    assign busy = (state != IDLE);     // Start is dropped while set.
    assign done = (state == UNLOAD);

endmodule

`default_nettype wire

// File: src/spi_clock_gen.sv
`timescale 1ns/1ps
`default_nettype none

module spi_clock_gen (
    input  logic spi_clk,
    input  logic rstn,
    input  logic run,
    output logic sclk_rise,
    output logic sclk_fall
);
    import spi_pkg::*;

    logic [DIV_WIDTH-1:0] div_cnt;
    logic                 phase;    // Low half done when set.
    logic                 tick;

    // ==================================================
    // Half period counter
    // ==================================================

    assign tick = run && (div_cnt == DIV_WIDTH'(SCLK_DIV - 1));

    always_ff @(posedge spi_clk)
    begin
        if (!rstn || !run)
        begin
            div_cnt <= '0;
            phase   <= 1'b0;    // Next pulse is a rise.
        end
        else if (tick)
        begin
            div_cnt <= '0;
            phase   <= ~phase;
        end
        else
        begin
            div_cnt <= div_cnt + 1'b1;
        end
    end

    // ==================================================
    // Edge enables
    // ==================================================

    // The first pulse after run rises is always a rise, so every frame
    // opens with a full low half period.
    assign sclk_rise = tick && !phase;
    assign sclk_fall = tick && phase;

endmodule

`default_nettype wire

// File: src/spi_pkg.sv
`default_nettype none

package spi_pkg;

    // ==================================================
    // Word and transfer sizes
    // ==================================================

    localparam int WORD_WIDTH = 8;   // Bits per data word.
    localparam int SIZE_WIDTH = 4;   // Holds a size of 0 to 8.

    // ==================================================
    // Serial clock divider
    // ==================================================

    localparam int SCLK_DIV  = 2;    // spi_clk cycles per sclk half period.
    localparam int DIV_WIDTH = 2;    // Wide enough for SCLK_DIV - 1.

    // ==================================================
    // Types
    // ==================================================

    typedef logic [WORD_WIDTH-1:0] word_t;
    typedef logic [SIZE_WIDTH-1:0] size_t;

    // Reply of the echo target until the first frame ends.
    localparam word_t TARGET_RESET_REPLY = 8'hA5;

    // Host request taken with the start pulse.
    typedef struct packed {
        word_t data;    // Top bits sent MSB first.
        size_t size;    // Number of bits to move.
    } xfer_req_t;

    // Pins driven by the master.
    typedef struct packed {
        logic sclk;
        logic mosi;
        logic cs_n;
    } spi_bus_t;

endpackage

`default_nettype wire
